// File: design/udp_echo_pkg.sv
package udp_echo_pkg;

    localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
    localparam logic [7:0]  IP_PROTO_UDP   = 8'd17;
    localparam logic [7:0]  IP_VER_IHL     = 8'h45;
    localparam logic [7:0]  REPLY_TTL      = 8'd64;

    // Ethernet + IPv4 (no options) + UDP header length in bytes
    localparam int HDR_BYTES = 42;

    // byte offsets of the fields inside a received frame
    localparam int OFF_SRC_MAC   = 6;
    localparam int OFF_ETHERTYPE = 12;
    localparam int OFF_VER_IHL   = 14;
    localparam int OFF_PROTO     = 23;
    localparam int OFF_SRC_IP    = 26;
    localparam int OFF_DST_IP    = 30;
    localparam int OFF_SRC_PORT  = 34;
    localparam int OFF_DST_PORT  = 36;
    localparam int OFF_UDP_LEN   = 38;
    localparam int OFF_UDP_CSUM  = 40;

    typedef struct packed {
        logic [47:0] src_mac;
        logic [31:0] dst_ip;
        logic [31:0] src_ip;
        logic [15:0] src_port;
        logic [15:0] dst_port;
        logic [15:0] udp_length;
    } udp_hdr_t;

    typedef struct packed {
        logic [47:0] dst_mac;
        logic [31:0] dst_ip;
        logic [15:0] src_port;
        logic [15:0] dst_port;
        logic [15:0] udp_length;
    } reply_hdr_t;

    typedef struct packed {
        logic [7:0] data;
        logic       last;
    } stream_byte_t;

endpackage

// File: design/sync_fifo.sv
`default_nettype none
`timescale 1ns/1ps

module sync_fifo #(
    parameter type item_t = logic [7:0],
    parameter int  DEPTH  = 16
) (
    input  var logic  udp_sys_clk,
    input  var logic  rst,
    input  var logic  wr_en,
    input  var item_t wr_item,
    input  var logic  rd_en,
    output item_t     rd_item,
    output logic      empty,
    output logic      full
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    item_t         mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          do_wr;
    logic          do_rd;

    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    // first word fall through, the head item is always on rd_item
    assign rd_item = mem[rd_ptr];
    assign empty   = (count == '0);
    assign full    = (count == (AW+1)'(DEPTH));

    always_ff @(posedge udp_sys_clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_item;
        end
    end

    always_ff @(posedge udp_sys_clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

    // the producer and consumer must both honour the flags
    assert property (@(posedge udp_sys_clk) disable iff (rst) !(wr_en && full))
        else $error("sync_fifo: write while full");
    assert property (@(posedge udp_sys_clk) disable iff (rst) !(rd_en && empty))
        else $error("sync_fifo: read while empty");

endmodule

`default_nettype wire

// File: design/udp_rx_parser.sv
`default_nettype none
`timescale 1ns/1ps

module udp_rx_parser import udp_echo_pkg::*; (
    input  var logic     udp_sys_clk,
    input  var logic     rst,
    input  var logic [7:0] in_data,
    input  var logic     in_valid,
    input  var logic     in_last,
    input  var logic     pl_full,
    input  var logic     hdr_full,
    output logic         in_ready,
    output logic         pl_wr,
    output stream_byte_t pl_item,
    output logic         hdr_wr,
    output udp_hdr_t     hdr_item
);

    // cnt holds the index of the next byte and 43 stands for any later payload byte
    logic [5:0] cnt;
    logic       skip;
    logic       reject;
    logic       bad;
    logic       accept;
    udp_hdr_t   hdr_q;

    always_comb begin
        if (skip) begin
            in_ready = 1'b1;
        end else if (cnt < HDR_BYTES) begin
            in_ready = !hdr_full;
        end else if (cnt == 6'(HDR_BYTES)) begin
            in_ready = !pl_full && !hdr_full;
        end else begin
            in_ready = !pl_full;
        end
    end

    assign accept  = in_valid && in_ready;
    assign pl_wr   = accept && !skip && (cnt >= HDR_BYTES);
    assign hdr_wr  = accept && !skip && (cnt == 6'(HDR_BYTES));
    assign pl_item = '{data: in_data, last: in_last};
    assign hdr_item = hdr_q;

    // protocol checks on the byte currently presented
    always_comb begin
        bad = 1'b0;
        if (cnt == OFF_ETHERTYPE) begin
            bad = (in_data != ETHERTYPE_IPV4[15:8]);
        end else if (cnt == OFF_ETHERTYPE + 1) begin
            bad = (in_data != ETHERTYPE_IPV4[7:0]);
        end else if (cnt == OFF_VER_IHL) begin
            bad = (in_data != IP_VER_IHL);
        end else if (cnt == OFF_PROTO) begin
            bad = (in_data != IP_PROTO_UDP);
        end
    end

    always_ff @(posedge udp_sys_clk) begin
        if (rst) begin
            cnt    <= '0;
            skip   <= 1'b0;
            reject <= 1'b0;
        end else if (accept) begin
            if (skip) begin
                if (in_last) begin
                    skip <= 1'b0;
                end
            end else if (in_last) begin
                // a frame ending inside the header is simply forgotten
                cnt    <= '0;
                reject <= 1'b0;
            end else if (cnt == 6'(HDR_BYTES - 1) && (reject || bad)) begin
                skip   <= 1'b1;
                cnt    <= '0;
                reject <= 1'b0;
            end else begin
                reject <= reject | bad;
                if (cnt != 6'(HDR_BYTES + 1)) begin
                    cnt <= cnt + 6'd1;
                end
            end
        end
    end

    // header fields arrive most significant byte first
    always_ff @(posedge udp_sys_clk) begin
        if (accept && !skip && cnt < HDR_BYTES) begin
            if (cnt >= OFF_SRC_MAC && cnt < OFF_ETHERTYPE) begin
                hdr_q.src_mac <= {hdr_q.src_mac[39:0], in_data};
            end
            if (cnt >= OFF_SRC_IP && cnt < OFF_DST_IP) begin
                hdr_q.src_ip <= {hdr_q.src_ip[23:0], in_data};
            end
            if (cnt >= OFF_DST_IP && cnt < OFF_SRC_PORT) begin
                hdr_q.dst_ip <= {hdr_q.dst_ip[23:0], in_data};
            end
            if (cnt >= OFF_SRC_PORT && cnt < OFF_DST_PORT) begin
                hdr_q.src_port <= {hdr_q.src_port[7:0], in_data};
            end
            if (cnt >= OFF_DST_PORT && cnt < OFF_UDP_LEN) begin
                hdr_q.dst_port <= {hdr_q.dst_port[7:0], in_data};
            end
            if (cnt >= OFF_UDP_LEN && cnt < OFF_UDP_CSUM) begin
                hdr_q.udp_length <= {hdr_q.udp_length[7:0], in_data};
            end
        end
    end

    // a header record is only pushed for a frame that passed every protocol check
    assert property (@(posedge udp_sys_clk) disable iff (rst) hdr_wr |-> !reject)
        else $error("udp_rx_parser: header pushed for a rejected frame");

endmodule

`default_nettype wire

// File: design/echo_controller.sv
`default_nettype none
`timescale 1ns/1ps

module echo_controller import udp_echo_pkg::*; #(
    parameter logic [31:0] LOCAL_IP = {8'd192, 8'd168, 8'd1, 8'd128}
) (
    input  var logic     udp_sys_clk,
    input  var logic     rst,
    input  var logic     hdr_valid,
    input  var udp_hdr_t hdr_item,
    input  var logic     tx_done,
    output logic         hdr_pop,
    output logic         tx_start,
    output logic         tx_drop,
    output reply_hdr_t   reply_hdr,
    output logic [15:0]  echo_count,
    output logic [15:0]  drop_count
);

    typedef enum logic {IDLE, BUSY} state_t;

    state_t state;
    logic   start_q;
    logic   take;

    assign take     = (state == IDLE) && hdr_valid && !start_q;
    assign tx_start = start_q;
    assign hdr_pop  = start_q;

    always_ff @(posedge udp_sys_clk) begin
        if (rst) begin
            state      <= IDLE;
            start_q    <= 1'b0;
            echo_count <= '0;
            drop_count <= '0;
        end else begin
            start_q <= take;
            case (state)
                IDLE: begin
                    if (start_q) begin
                        state <= BUSY;
                    end
                end
                BUSY: begin
                    if (tx_done) begin
                        state <= IDLE;
                        if (tx_drop) begin
                            drop_count <= drop_count + 16'd1;
                        end else begin
                            echo_count <= echo_count + 16'd1;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // reply fields are held for the whole frame so the framer reads them directly
    always_ff @(posedge udp_sys_clk) begin
        if (take) begin
            tx_drop              <= (hdr_item.dst_ip != LOCAL_IP);
            reply_hdr.dst_mac    <= hdr_item.src_mac;
            reply_hdr.dst_ip     <= hdr_item.src_ip;
            reply_hdr.src_port   <= hdr_item.src_port;
            reply_hdr.dst_port   <= hdr_item.dst_port;
            reply_hdr.udp_length <= hdr_item.udp_length;
        end
    end

    assert property (@(posedge udp_sys_clk) disable iff (rst) tx_done |-> state == BUSY)
        else $error("echo_controller: tx_done without an outstanding frame");

endmodule

`default_nettype wire

// File: design/udp_tx_framer.sv
`default_nettype none
`timescale 1ns/1ps

module udp_tx_framer import udp_echo_pkg::*; #(
    parameter logic [47:0] LOCAL_MAC = 48'h02_00_00_00_00_01,
    parameter logic [31:0] LOCAL_IP  = {8'd192, 8'd168, 8'd1, 8'd128}
) (
    input  var logic         udp_sys_clk,
    input  var logic         rst,
    input  var logic         tx_start,
    input  var logic         tx_drop,
    input  var reply_hdr_t   reply_hdr,
    input  var stream_byte_t pl_item,
    input  var logic         pl_empty,
    input  var logic         out_ready,
    output logic             pl_rd,
    output logic             tx_done,
    output logic [7:0]       out_data,
    output logic             out_valid,
    output logic             out_last
);

    typedef enum logic [2:0] {F_IDLE, F_SUM, F_HDR, F_PAYLOAD, F_DRAIN} state_t;

    state_t       state;
    logic [5:0]   idx;
    logic [15:0]  total_len;
    logic [19:0]  word_sum;
    logic [19:0]  sum_q;
    logic [16:0]  fold1;
    logic [15:0]  fold2;
    logic [15:0]  csum_q;
    logic [335:0] hdr_bytes;

    // id, flags/fragment and the checksum field itself are zero and drop out of the sum
    always_comb begin
        total_len = reply_hdr.udp_length + 16'd20;
        word_sum  = 20'({IP_VER_IHL, 8'h00}) + 20'(total_len)
                  + 20'({REPLY_TTL, IP_PROTO_UDP})
                  + 20'(LOCAL_IP[31:16]) + 20'(LOCAL_IP[15:0])
                  + 20'(reply_hdr.dst_ip[31:16]) + 20'(reply_hdr.dst_ip[15:0]);
        fold1 = 17'(sum_q[15:0]) + 17'(sum_q[19:16]);
        fold2 = fold1[15:0] + 16'(fold1[16]);
    end

    assign hdr_bytes = {
        reply_hdr.dst_mac, LOCAL_MAC, ETHERTYPE_IPV4,
        IP_VER_IHL, 8'h00, total_len, 16'h0000, 16'h0000,
        REPLY_TTL, IP_PROTO_UDP, csum_q, LOCAL_IP, reply_hdr.dst_ip,
        reply_hdr.src_port, reply_hdr.dst_port, reply_hdr.udp_length, 16'h0000
    };

    always_comb begin
        out_valid = 1'b0;
        out_last  = 1'b0;
        out_data  = hdr_bytes[8 * (HDR_BYTES - 1 - int'(idx)) +: 8];
        if (state == F_HDR) begin
            out_valid = 1'b1;
        end else if (state == F_PAYLOAD) begin
            out_valid = !pl_empty;
            out_data  = pl_item.data;
            out_last  = pl_item.last;
        end
    end

    // in drop mode every available byte is thrown away
    assign pl_rd = !pl_empty && ((state == F_PAYLOAD && out_ready) || state == F_DRAIN);

    always_ff @(posedge udp_sys_clk) begin
        if (rst) begin
            state   <= F_IDLE;
            idx     <= '0;
            tx_done <= 1'b0;
        end else begin
            tx_done <= 1'b0;
            case (state)
                F_IDLE: begin
                    idx <= '0;
                    if (tx_start) begin
                        state <= tx_drop ? F_DRAIN : F_SUM;
                    end
                end
                F_SUM: state <= F_HDR;
                F_HDR: begin
                    if (out_ready) begin
                        if (idx == 6'(HDR_BYTES - 1)) begin
                            state <= F_PAYLOAD;
                        end else begin
                            idx <= idx + 6'd1;
                        end
                    end
                end
                F_PAYLOAD, F_DRAIN: begin
                    if (pl_rd && pl_item.last) begin
                        state   <= F_IDLE;
                        tx_done <= 1'b1;
                    end
                end
                default: state <= F_IDLE;
            endcase
        end
    end

    // the raw sum is taken on the start strobe and folded and inverted one cycle later
    always_ff @(posedge udp_sys_clk) begin
        if (state == F_IDLE && tx_start) begin
            sum_q <= word_sum;
        end
        if (state == F_SUM) begin
            csum_q <= ~fold2;
        end
    end

    assert property (@(posedge udp_sys_clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_last))
        else $error("udp_tx_framer: output changed while stalled");

endmodule

`default_nettype wire

// File: design/udp_echo_top.sv
`default_nettype none
`timescale 1ns/1ps

module udp_echo_top import udp_echo_pkg::*; #(
    parameter logic [47:0] LOCAL_MAC     = 48'h02_00_00_00_00_01,
    parameter logic [31:0] LOCAL_IP      = {8'd192, 8'd168, 8'd1, 8'd128},
    parameter int          PAYLOAD_DEPTH = 2048,
    parameter int          HDR_DEPTH     = 4
) (
    input  var logic       udp_sys_clk,
    input  var logic       rst,
    input  var logic [7:0] in_data,
    input  var logic       in_valid,
    input  var logic       in_last,
    input  var logic       out_ready,
    output logic           in_ready,
    output logic [7:0]     out_data,
    output logic           out_valid,
    output logic           out_last,
    output logic [15:0]    echo_count,
    output logic [15:0]    drop_count
);

    logic         pl_wr;
    logic         pl_rd;
    logic         pl_full;
    logic         pl_empty;
    stream_byte_t pl_wr_item;
    stream_byte_t pl_rd_item;

    logic         hdr_wr;
    logic         hdr_pop;
    logic         hdr_full;
    logic         hdr_empty;
    logic         hdr_valid;
    udp_hdr_t     hdr_wr_item;
    udp_hdr_t     hdr_rd_item;

    logic         tx_start;
    logic         tx_drop;
    logic         tx_done;
    reply_hdr_t   reply_hdr;

    assign hdr_valid = !hdr_empty;

    udp_rx_parser parser_inst (
        .udp_sys_clk(udp_sys_clk),
        .rst(rst),
        .in_data(in_data),
        .in_valid(in_valid),
        .in_last(in_last),
        .pl_full(pl_full),
        .hdr_full(hdr_full),
        .in_ready(in_ready),
        .pl_wr(pl_wr),
        .pl_item(pl_wr_item),
        .hdr_wr(hdr_wr),
        .hdr_item(hdr_wr_item)
    );

    // payload bytes wait here while the controller and framer work on earlier frames
    sync_fifo #(.item_t(stream_byte_t), .DEPTH(PAYLOAD_DEPTH)) payload_fifo_inst (
        .udp_sys_clk(udp_sys_clk),
        .rst(rst),
        .wr_en(pl_wr),
        .wr_item(pl_wr_item),
        .rd_en(pl_rd),
        .rd_item(pl_rd_item),
        .empty(pl_empty),
        .full(pl_full)
    );

    sync_fifo #(.item_t(udp_hdr_t), .DEPTH(HDR_DEPTH)) hdr_fifo_inst (
        .udp_sys_clk(udp_sys_clk),
        .rst(rst),
        .wr_en(hdr_wr),
        .wr_item(hdr_wr_item),
        .rd_en(hdr_pop),
        .rd_item(hdr_rd_item),
        .empty(hdr_empty),
        .full(hdr_full)
    );

    echo_controller #(.LOCAL_IP(LOCAL_IP)) controller_inst (
        .udp_sys_clk(udp_sys_clk),
        .rst(rst),
        .hdr_valid(hdr_valid),
        .hdr_item(hdr_rd_item),
        .tx_done(tx_done),
        .hdr_pop(hdr_pop),
        .tx_start(tx_start),
        .tx_drop(tx_drop),
        .reply_hdr(reply_hdr),
        .echo_count(echo_count),
        .drop_count(drop_count)
    );

    udp_tx_framer #(.LOCAL_MAC(LOCAL_MAC), .LOCAL_IP(LOCAL_IP)) framer_inst (
        .udp_sys_clk(udp_sys_clk),
        .rst(rst),
        .tx_start(tx_start),
        .tx_drop(tx_drop),
        .reply_hdr(reply_hdr),
        .pl_item(pl_rd_item),
        .pl_empty(pl_empty),
        .out_ready(out_ready),
        .pl_rd(pl_rd),
        .tx_done(tx_done),
        .out_data(out_data),
        .out_valid(out_valid),
        .out_last(out_last)
    );

endmodule

`default_nettype wire

// File: verification/udp_echo_checker.sv
`timescale 1ns/1ps

module udp_echo_checker import udp_echo_pkg::*; #(
    parameter logic [47:0] LOCAL_MAC = 48'h02_00_00_00_00_01,
    parameter logic [31:0] LOCAL_IP  = {8'd192, 8'd168, 8'd1, 8'd128}
) (
    input  logic        udp_sys_clk,
    input  logic        rst,
    input  logic [7:0]  in_data,
    input  logic        in_valid,
    input  logic        in_last,
    input  logic        in_ready,
    input  logic [7:0]  out_data,
    input  logic        out_valid,
    input  logic        out_last,
    input  logic        out_ready,
    input  logic [15:0] echo_count,
    input  logic [15:0] drop_count,
    input  logic        end_check,
    output logic        end_done,
    output int          outstanding,
    output int          mismatch_errors,
    output int          other_errors
);

    typedef logic [7:0] byte_q_t [$];

    byte_q_t    rx_frame;
    byte_q_t    reply_bytes;
    logic [8:0] exp_q [$];
    logic [8:0] head;
    int         verdict;
    int         echo_tally;
    int         drop_tally;

    // 0 means the parser ignores the frame, 1 a drop, 2 an echo with the reply in r
    function automatic int expected_reply(input byte_q_t f, output byte_q_t r);
        logic [7:0]  h [HDR_BYTES];
        logic [31:0] sum;
        logic [15:0] total_len;
        r = {};
        if (f.size() <= HDR_BYTES) begin
            return 0;
        end
        if ({f[12], f[13]} != ETHERTYPE_IPV4 || f[14] != IP_VER_IHL || f[23] != IP_PROTO_UDP) begin
            return 0;
        end
        if ({f[30], f[31], f[32], f[33]} != LOCAL_IP) begin
            return 1;
        end
        total_len = {f[38], f[39]} + 16'd20;
        foreach (h[i]) begin
            h[i] = 8'h00;
        end
        for (int i = 0; i < 6; i++) begin
            h[i]     = f[6 + i];
            h[6 + i] = LOCAL_MAC[8 * (5 - i) +: 8];
        end
        h[12] = ETHERTYPE_IPV4[15:8];
        h[13] = ETHERTYPE_IPV4[7:0];
        h[14] = IP_VER_IHL;
        h[16] = total_len[15:8];
        h[17] = total_len[7:0];
        h[22] = REPLY_TTL;
        h[23] = IP_PROTO_UDP;
        for (int i = 0; i < 4; i++) begin
            h[26 + i] = LOCAL_IP[8 * (3 - i) +: 8];
            h[30 + i] = f[26 + i];
        end
        // ports and UDP length come back as received and the UDP checksum stays zero
        for (int i = 34; i < 40; i++) begin
            h[i] = f[i];
        end
        sum = '0;
        for (int i = 14; i < 34; i += 2) begin
            sum = sum + {16'h0000, h[i], h[i + 1]};
        end
        while (sum[31:16] != 16'h0000) begin
            sum = {16'h0000, sum[15:0]} + {16'h0000, sum[31:16]};
        end
        h[24] = ~sum[15:8];
        h[25] = ~sum[7:0];
        foreach (h[i]) begin
            r.push_back(h[i]);
        end
        for (int i = HDR_BYTES; i < f.size(); i++) begin
            r.push_back(f[i]);
        end
        return 2;
    endfunction

    always @(posedge udp_sys_clk) begin
        if (rst) begin
            rx_frame        = {};
            exp_q           = {};
            verdict         = 0;
            echo_tally      = 0;
            drop_tally      = 0;
            mismatch_errors = 0;
            other_errors    = 0;
            outstanding     = 0;
            end_done        = 1'b0;
        end else begin
            if (in_valid && in_ready) begin
                rx_frame.push_back(in_data);
                // the header decision is made on the first payload byte as in the parser
                if (rx_frame.size() == HDR_BYTES + 1) begin
                    verdict = expected_reply(rx_frame, reply_bytes);
                    if (verdict == 2) begin
                        echo_tally++;
                        for (int i = 0; i < reply_bytes.size(); i++) begin
                            exp_q.push_back({reply_bytes[i],
                                             (i == reply_bytes.size() - 1) && in_last});
                        end
                    end else if (verdict == 1) begin
                        drop_tally++;
                    end
                end else if (rx_frame.size() > HDR_BYTES + 1 && verdict == 2) begin
                    exp_q.push_back({in_data, in_last});
                end
                if (in_last) begin
                    rx_frame = {};
                    verdict  = 0;
                end
            end
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    other_errors++;
                    $display("%0t: output byte %02h appeared with no reply expected",
                             $time, out_data);
                end else begin
                    head = exp_q.pop_front();
                    if (out_data !== head[8:1]) begin
                        mismatch_errors++;
                        $display("CHECK FAILED at %0t: out_data expected %02h got %02h",
                                 $time, head[8:1], out_data);
                    end
                    if (out_last !== head[0]) begin
                        mismatch_errors++;
                        $display("CHECK FAILED at %0t: out_last expected %0b got %0b",
                                 $time, head[0], out_last);
                    end
                end
            end
            if (end_check && !end_done) begin
                if (int'(echo_count) != echo_tally) begin
                    mismatch_errors++;
                    $display("CHECK FAILED at %0t: echo_count expected %0d got %0d",
                             $time, echo_tally, echo_count);
                end
                if (int'(drop_count) != drop_tally) begin
                    mismatch_errors++;
                    $display("CHECK FAILED at %0t: drop_count expected %0d got %0d",
                             $time, drop_tally, drop_count);
                end
                if (exp_q.size() != 0) begin
                    other_errors++;
                    $display("%0d expected reply bytes never came out", exp_q.size());
                end
                end_done = 1'b1;
            end
            // a finished frame stays outstanding until its counter has moved
            outstanding = exp_q.size() + (echo_tally - int'(echo_count))
                        + (drop_tally - int'(drop_count));
        end
    end

endmodule

// File: verification/udp_echo_tb.sv
`timescale 1ns/1ps

module udp_echo_tb;

    localparam logic [47:0] LOCAL_MAC = 48'h02_00_00_00_00_01;
    localparam logic [31:0] LOCAL_IP  = {8'd192, 8'd168, 8'd1, 8'd128};
    localparam logic [47:0] PEER_MAC  = 48'h0a_1b_2c_3d_4e_50;
    localparam logic [31:0] PEER_IP   = {8'd10, 8'd0, 8'd0, 8'd20};
    localparam logic [31:0] OTHER_IP  = {8'd192, 8'd168, 8'd1, 8'd129};
    localparam int          TIMEOUT   = 20000;

    logic        udp_sys_clk;
    logic        rst;
    logic [7:0]  in_data;
    logic        in_valid;
    logic        in_last;
    logic        in_ready;
    logic        out_ready;
    logic [7:0]  out_data;
    logic        out_valid;
    logic        out_last;
    logic [15:0] echo_count;
    logic [15:0] drop_count;
    logic        end_check;
    logic        end_done;
    int          outstanding;
    int          mismatch_errors;
    int          other_errors;

    logic [31:0] lfsr_state;
    logic [7:0]  frame_q [$];
    logic        backpressure;
    logic        gaps;
    int          timeouts;
    int          len;

    udp_echo_top #(.LOCAL_MAC(LOCAL_MAC), .LOCAL_IP(LOCAL_IP)) uut (
        .udp_sys_clk(udp_sys_clk),
        .rst(rst),
        .in_data(in_data),
        .in_valid(in_valid),
        .in_last(in_last),
        .out_ready(out_ready),
        .in_ready(in_ready),
        .out_data(out_data),
        .out_valid(out_valid),
        .out_last(out_last),
        .echo_count(echo_count),
        .drop_count(drop_count)
    );

    udp_echo_checker #(.LOCAL_MAC(LOCAL_MAC), .LOCAL_IP(LOCAL_IP)) reply_chk (
        .udp_sys_clk(udp_sys_clk),
        .rst(rst),
        .in_data(in_data),
        .in_valid(in_valid),
        .in_last(in_last),
        .in_ready(in_ready),
        .out_data(out_data),
        .out_valid(out_valid),
        .out_last(out_last),
        .out_ready(out_ready),
        .echo_count(echo_count),
        .drop_count(drop_count),
        .end_check(end_check),
        .end_done(end_done),
        .outstanding(outstanding),
        .mismatch_errors(mismatch_errors),
        .other_errors(other_errors)
    );

    initial udp_sys_clk = 1'b0;
    always #5 udp_sys_clk = ~udp_sys_clk;

    // x^32 + x^22 + x^2 + x + 1, one shift per bit handed out
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r          = {r[30:0], fb};
        end
        return r;
    endfunction

    // every input change happens here on the falling edge
    task automatic tick();
        @(negedge udp_sys_clk);
        if (backpressure) begin
            out_ready = (random_bits(2) != 2'b00);
        end else begin
            out_ready = 1'b1;
        end
    endtask

    function automatic void push_field(input logic [47:0] value, input int nbytes);
        for (int i = nbytes - 1; i >= 0; i--) begin
            frame_q.push_back(value[8 * i +: 8]);
        end
    endfunction

    function automatic void build_frame(input logic [47:0] src_mac, input logic [31:0] src_ip,
                                        input logic [31:0] dst_ip, input logic [15:0] ethertype,
                                        input logic [7:0] proto, input int payload_len);
        frame_q = {};
        push_field(LOCAL_MAC, 6);
        push_field(src_mac, 6);
        push_field(48'(ethertype), 2);
        push_field(48'h45, 1);
        // nonzero DSCP and a TTL other than 64, the reply must rewrite both
        push_field(48'hb8, 1);
        push_field(48'(payload_len + 28), 2);
        push_field(48'h0, 4);
        push_field(48'd32, 1);
        push_field(48'(proto), 1);
        push_field(48'h0, 2);
        push_field(48'(src_ip), 4);
        push_field(48'(dst_ip), 4);
        push_field(48'(random_bits(16)), 2);
        push_field(48'd7, 2);
        push_field(48'(payload_len + 8), 2);
        push_field(48'h0, 2);
        for (int i = 0; i < payload_len; i++) begin
            frame_q.push_back(8'(random_bits(8)));
        end
    endfunction

    function automatic void truncate_frame(input int n);
        while (frame_q.size() > n) begin
            void'(frame_q.pop_back());
        end
    endfunction

    task automatic send_frame();
        int waited;
        int idle;
        for (int i = 0; i < frame_q.size(); i++) begin
            if (timeouts != 0) begin
                return;
            end
            if (gaps && random_bits(3) == 32'd0) begin
                idle = int'(random_bits(2)) + 1;
                repeat (idle) tick();
            end
            in_data  = frame_q[i];
            in_last  = (i == frame_q.size() - 1);
            in_valid = 1'b1;
            waited   = 0;
            // in_ready only depends on registers, so it holds until the next rising edge
            while (!in_ready && waited < TIMEOUT) begin
                tick();
                waited++;
            end
            if (!in_ready) begin
                $display("in_ready stayed low for %0d cycles at %0t", TIMEOUT, $time);
                timeouts++;
            end
            tick();
            in_valid = 1'b0;
            in_last  = 1'b0;
        end
    endtask

    task automatic wait_idle();
        int waited;
        if (timeouts != 0) begin
            return;
        end
        waited = 0;
        while (outstanding != 0 && waited < TIMEOUT) begin
            tick();
            waited++;
        end
        if (outstanding != 0) begin
            $display("replies were still outstanding after %0d cycles at %0t", TIMEOUT, $time);
            timeouts++;
        end
    endtask

    task automatic collect_results();
        int waited;
        if (timeouts != 0) begin
            return;
        end
        end_check = 1'b1;
        waited    = 0;
        while (!end_done && waited < TIMEOUT) begin
            tick();
            waited++;
        end
        end_check = 1'b0;
        if (!end_done) begin
            $display("the checker never finished its closing checks");
            timeouts++;
        end
    endtask

    initial begin
        lfsr_state   = 32'h5f3c_e522;
        rst          = 1'b1;
        in_data      = 8'h00;
        in_valid     = 1'b0;
        in_last      = 1'b0;
        out_ready    = 1'b1;
        end_check    = 1'b0;
        backpressure = 1'b0;
        gaps         = 1'b0;
        timeouts     = 0;
        repeat (2) @(posedge udp_sys_clk);
        @(negedge udp_sys_clk);
        rst = 1'b0;
        tick();

        build_frame(PEER_MAC, PEER_IP, LOCAL_IP, 16'h0800, 8'd17, 16);
        send_frame();

        // dropped frame, then an echo that must not carry any of its payload
        build_frame(PEER_MAC + 1, PEER_IP + 1, OTHER_IP, 16'h0800, 8'd17, 20);
        send_frame();
        build_frame(PEER_MAC + 2, PEER_IP + 2, LOCAL_IP, 16'h0800, 8'd17, 5);
        send_frame();

        build_frame(PEER_MAC + 3, PEER_IP + 3, LOCAL_IP, 16'h86dd, 8'd17, 12);
        send_frame();
        build_frame(PEER_MAC + 4, PEER_IP + 4, LOCAL_IP, 16'h0800, 8'd6, 12);
        send_frame();
        build_frame(PEER_MAC + 5, PEER_IP + 5, LOCAL_IP, 16'h0800, 8'd17, 12);
        truncate_frame(30);
        send_frame();
        build_frame(PEER_MAC + 6, PEER_IP + 6, LOCAL_IP, 16'h0800, 8'd17, 12);
        truncate_frame(42);
        send_frame();
        build_frame(PEER_MAC + 7, PEER_IP + 7, LOCAL_IP, 16'h0800, 8'd17, 1);
        send_frame();
        wait_idle();

        backpressure = 1'b1;
        gaps         = 1'b1;
        for (int k = 0; k < 12; k++) begin
            len = int'(random_bits(9)) % 300 + 1;
            build_frame(PEER_MAC + 8 + k, PEER_IP + 8 + k, (k == 5) ? OTHER_IP : LOCAL_IP,
                        16'h0800, 8'd17, len);
            send_frame();
        end
        wait_idle();
        collect_results();

        $display("error counts: compare=%0d other=%0d timeout=%0d",
                 mismatch_errors, other_errors, timeouts);
        if (mismatch_errors == 0 && other_errors == 0 && timeouts == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: compile.f
design/udp_echo_pkg.sv
design/sync_fifo.sv
design/udp_rx_parser.sv
design/echo_controller.sv
design/udp_tx_framer.sv
design/udp_echo_top.sv
verification/udp_echo_checker.sv
verification/udp_echo_tb.sv
